// ==== dv/stats_tb.sv ====
`timescale 1ns/1ps
`include "stats_cfg.svh"

module stats_tb;

  // One cycle of stimulus
  typedef struct packed {
    stats_pkg::stat_vec_t inc;
    stats_pkg::stat_vec_t dec;
    logic                 clr_all;
    logic                 rd;
    stats_pkg::stat_idx_t addr;
    logic                 rd_clr;
  } row_t;

  logic                 clk;
  logic                 rst_n;
  stats_pkg::stat_vec_t evt_inc;
  stats_pkg::stat_vec_t evt_dec;
  logic                 clear_all;
  logic                 rd_en;
  stats_pkg::stat_idx_t rd_addr;
  logic                 rd_clear;
  logic                 rd_valid;
  stats_pkg::stat_cnt_t rd_data;

  row_t                 rows [$];
  stats_pkg::stat_cnt_t delay [`STATS_STAGES+1][`STATS_NUM]; // Index 0 is the live count
  logic                 exp_valid;
  stats_pkg::stat_cnt_t exp_data;
  int                   cycle_cnt = 0;
  int                   cycle_limit = 1000;

  stats_top UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .evt_inc  (evt_inc),
    .evt_dec  (evt_dec),
    .clear_all(clear_all),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_clear (rd_clear),
    .rd_valid (rd_valid),
    .rd_data  (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: the stimulus table did not finish within %0d cycles", cycle_limit);
      $display(">>> FAIL");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display(">>> FAIL");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  task automatic add_row(input stats_pkg::stat_vec_t inc, input stats_pkg::stat_vec_t dec,
                         input logic clr_all, input logic rd, input int addr,
                         input logic rd_clr);
    row_t r;
    r.inc     = inc;
    r.dec     = dec;
    r.clr_all = clr_all;
    r.rd      = rd;
    r.addr    = stats_pkg::stat_idx_t'(addr);
    r.rd_clr  = rd_clr;
    rows.push_back(r);
  endtask

  task automatic add_idle(input int n);
    for (int k = 0; k < n; k++) begin
      add_row('0, '0, 1'b0, 1'b0, 0, 1'b0);
    end
  endtask

  task automatic add_read(input int addr, input logic rd_clr);
    add_row('0, '0, 1'b0, 1'b1, addr, rd_clr);
  endtask

  task automatic build_table();
    for (int i = 0; i < `STATS_NUM; i++) add_read(i, 1'b0); // Fresh counters read zero
    repeat (5) add_row(4'b0010, '0, 1'b0, 1'b0, 0, 1'b0);
    add_idle(`STATS_STAGES + 1);
    add_read(1, 1'b0);
    add_read(0, 1'b0);
    add_read(2, 1'b0);
    repeat (2) add_row('0, 4'b0010, 1'b0, 1'b0, 0, 1'b0);
    repeat (3) add_row(4'b0010, 4'b0010, 1'b0, 1'b0, 0, 1'b0);
    add_row('0, 4'b1000, 1'b0, 1'b0, 0, 1'b0); // Counter 3 goes below zero
    add_idle(`STATS_STAGES + 1);
    add_read(1, 1'b0);
    add_read(3, 1'b0);
    add_row(4'b1111, '0, 1'b1, 1'b0, 0, 1'b0); // Global clear beats inc
    add_row(4'b0100, '0, 1'b0, 1'b0, 0, 1'b0);
    add_idle(`STATS_STAGES + 1);
    for (int i = 0; i < `STATS_NUM; i++) add_read(i, 1'b0);
    repeat (3) add_row(4'b0001, '0, 1'b0, 1'b0, 0, 1'b0);
    add_idle(`STATS_STAGES + 1);
    add_read(0, 1'b1);
    add_row(4'b0001, '0, 1'b0, 1'b0, 0, 1'b0);
    add_idle(`STATS_STAGES + 1);
    add_read(0, 1'b0);
    // Reads on every cycle against random traffic
    for (int n = 0; n < 64; n++) begin
      add_row(stats_pkg::stat_vec_t'($urandom), stats_pkg::stat_vec_t'($urandom),
              ($urandom % 16) == 0, 1'b1, $urandom % `STATS_NUM, ($urandom % 4) == 0);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Reference model, one clock edge per call
  ////////////////////////////////////////////////////////////////////////

  task automatic model_step(input row_t r);
    logic clr;
    if (r.rd) exp_data = delay[`STATS_STAGES][r.addr];
    exp_valid = r.rd;
    for (int k = `STATS_STAGES; k > 0; k--) begin
      for (int i = 0; i < `STATS_NUM; i++) delay[k][i] = delay[k-1][i];
    end
    for (int i = 0; i < `STATS_NUM; i++) begin
      clr = r.clr_all || (r.rd && r.rd_clr && r.addr == stats_pkg::stat_idx_t'(i));
      if (clr) begin
        delay[0][i] = '0;
      end else if (r.inc[i] && !r.dec[i]) begin
        delay[0][i] = delay[0][i] + 1'b1;
      end else if (r.dec[i] && !r.inc[i]) begin
        delay[0][i] = delay[0][i] - 1'b1;
      end
    end
  endtask

  initial begin
    void'($urandom(32'hcb04_227c));
    rst_n     = 1'b0;
    evt_inc   = '0;
    evt_dec   = '0;
    clear_all = 1'b0;
    rd_en     = 1'b0;
    rd_addr   = '0;
    rd_clear  = 1'b0;
    exp_valid = 1'b0;
    exp_data  = '0;
    for (int k = 0; k <= `STATS_STAGES; k++) begin
      for (int i = 0; i < `STATS_NUM; i++) delay[k][i] = '0;
    end
    build_table();
    cycle_limit = rows.size() + 20;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    foreach (rows[n]) begin
      check_value("rd_valid", 32'(rd_valid), 32'(exp_valid));
      check_value("rd_data", 32'(rd_data), 32'(exp_data));
      evt_inc   = rows[n].inc;
      evt_dec   = rows[n].dec;
      clear_all = rows[n].clr_all;
      rd_en     = rows[n].rd;
      rd_addr   = rows[n].addr;
      rd_clear  = rows[n].rd_clr;
      model_step(rows[n]);
      @(negedge clk);
    end
    check_value("rd_valid", 32'(rd_valid), 32'(exp_valid));
    check_value("rd_data", 32'(rd_data), 32'(exp_data));
    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module stats_tb \
  > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/Vstats_tb > sim.log 2>&1
cat sim.log
grep -q '>>> FAIL' sim.log && exit 1
grep -q '>>> PASS' sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

// ==== sim.f ====
+incdir+source
source/stats_pkg.sv
source/stats_if.sv
source/stats_counter.sv
source/stats_readout.sv
source/stats_top.sv
dv/stats_tb.sv

// ==== source/stats_cfg.svh ====
`ifndef STATS_CFG_SVH
`define STATS_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Statistics block configuration
//////////////////////////////////////////////////////////////////////

// Width of every event counter in bits
`define STATS_CNT_W 16

// Register stages between the live count and the read path
// Zero hands the live count straight to the readout
`define STATS_STAGES 1

// Number of independent counters
`define STATS_NUM 4

`endif

// ==== source/stats_counter.sv ====
`timescale 1ns/1ps
`include "stats_cfg.svh"

module stats_counter (
  input logic     clk,
  input logic     rst_n,
  stats_if.counter port
);

  //////////////////////////////////////////////////////////////////////
  // Live count
  //////////////////////////////////////////////////////////////////////

  stats_pkg::stat_cnt_t cnt_live;

  // Clear beats both strobes while inc and dec together cancel out
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt_live <= '0;
    end else if (port.clear) begin
      cnt_live <= '0;
    end else if (port.inc && !port.dec) begin
      cnt_live <= cnt_live + 1'b1; // Wraps to zero past all ones
    end else if (port.dec && !port.inc) begin
      cnt_live <= cnt_live - 1'b1; // Wraps to all ones below zero
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output pipeline toward the read path
  //////////////////////////////////////////////////////////////////////

  generate
    if (`STATS_STAGES == 0) begin : g_direct

      assign port.cnt = cnt_live;

    end else begin : g_pipe

      stats_pkg::stat_cnt_t cnt_pipe [`STATS_STAGES];

      for (genvar s = 0; s < `STATS_STAGES; s++) begin : g_stage
        if (s == 0) begin : g_first
          always_ff @(posedge clk) begin
            if (!rst_n) begin
              cnt_pipe[s] <= '0;
            end else begin
              cnt_pipe[s] <= cnt_live;
            end
          end
        end else begin : g_next
          always_ff @(posedge clk) begin
            if (!rst_n) begin
              cnt_pipe[s] <= '0;
            end else begin
              cnt_pipe[s] <= cnt_pipe[s-1];
            end
          end
        end
      end

      assign port.cnt = cnt_pipe[`STATS_STAGES-1]; // Oldest stage

    end
  endgenerate

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // The strobes come from outside this block and must be resolved
  a_strobes_known : assert property (
    @(posedge clk) disable iff (!rst_n)
      !$isunknown({port.clear, port.inc, port.dec})
  ) else $error("stats_counter: unknown strobe");

endmodule

// ==== source/stats_if.sv ====
`timescale 1ns/1ps

interface stats_if;

  // Strobes into one counter
  logic clear;
  logic inc;
  logic dec;

  // Delayed count out of the counter
  stats_pkg::stat_cnt_t cnt;

  // Counter side sees the strobes and owns the count
  modport counter (
    input  clear,
    input  inc,
    input  dec,
    output cnt
  );

  // Readout side owns the clear and samples the count
  modport ctrl (
    output clear,
    input  cnt
  );

endinterface

// ==== source/stats_pkg.sv ====
`include "stats_cfg.svh"

package stats_pkg;

  //////////////////////////////////////////////////////////////////////
  // Shared types of the statistics block
  //////////////////////////////////////////////////////////////////////

  // One counter value, wraps at 2**STATS_CNT_W
  typedef logic [`STATS_CNT_W-1:0] stat_cnt_t;

  // Counter index, kept at least one bit wide for a single counter
  typedef logic [(`STATS_NUM > 1 ? $clog2(`STATS_NUM) : 1)-1:0] stat_idx_t;

  // One strobe bit per counter
  typedef logic [`STATS_NUM-1:0] stat_vec_t;

endpackage

// ==== source/stats_readout.sv ====
`timescale 1ns/1ps
`include "stats_cfg.svh"

module stats_readout (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rd_en,
  input  stats_pkg::stat_idx_t rd_addr,
  input  logic                 rd_clear,
  input  logic                 clear_all,
  output logic                 rd_valid,
  output stats_pkg::stat_cnt_t rd_data,
  stats_if.ctrl                stats [`STATS_NUM]
);

  stats_pkg::stat_cnt_t cnt_arr [`STATS_NUM];
  stats_pkg::stat_cnt_t sel_cnt;

  //////////////////////////////////////////////////////////////////////
  // Per-counter clear and count gathering
  //////////////////////////////////////////////////////////////////////

  generate
    for (genvar i = 0; i < `STATS_NUM; i++) begin : g_chan
      // Clear-on-read hits only the addressed counter
      assign stats[i].clear = clear_all |
                              (rd_en & rd_clear & (rd_addr == stats_pkg::stat_idx_t'(i)));

      assign cnt_arr[i] = stats[i].cnt;
    end
  endgenerate

  // An address past the last counter reads as zero
  always_comb begin
    sel_cnt = '0;
    for (int i = 0; i < `STATS_NUM; i++) begin
      if (rd_addr == stats_pkg::stat_idx_t'(i)) begin
        sel_cnt = cnt_arr[i];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read response register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
      rd_data  <= '0;
    end else begin
      rd_valid <= rd_en; // One-cycle pulse per read
      if (rd_en) begin
        rd_data <= sel_cnt; // Value before any clear of the same cycle
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  a_addr_range : assert property (
    @(posedge clk) disable iff (!rst_n)
      rd_en |-> (rd_addr < `STATS_NUM)
  ) else $error("stats_readout: read address out of range");

endmodule

// ==== source/stats_top.sv ====
`timescale 1ns/1ps
`include "stats_cfg.svh"

module stats_top (
  input  logic                 clk,
  input  logic                 rst_n,

  // Per-cycle event strobes, one bit per counter
  input  stats_pkg::stat_vec_t evt_inc,
  input  stats_pkg::stat_vec_t evt_dec,

  // Global clear
  input  logic                 clear_all,

  // Read request
  input  logic                 rd_en,
  input  stats_pkg::stat_idx_t rd_addr,
  input  logic                 rd_clear,

  // Read response, one cycle after rd_en
  output logic                 rd_valid,
  output stats_pkg::stat_cnt_t rd_data
);

  //////////////////////////////////////////////////////////////////////
  // Counter array
  //////////////////////////////////////////////////////////////////////

  stats_if stats [`STATS_NUM] ();

  generate
    for (genvar i = 0; i < `STATS_NUM; i++) begin : g_cnt

      // Event strobes go straight in, the readout owns the clear
      assign stats[i].inc = evt_inc[i];
      assign stats[i].dec = evt_dec[i];

      stats_counter u_counter (
        .clk  (clk),
        .rst_n(rst_n),
        .port (stats[i])
      );

    end
  endgenerate

  //////////////////////////////////////////////////////////////////////
  // Readout
  //////////////////////////////////////////////////////////////////////

  stats_readout u_readout (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_clear (rd_clear),
    .clear_all(clear_all),
    .rd_valid (rd_valid),
    .rd_data  (rd_data),
    .stats    (stats)
  );

endmodule
